//--- hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	localparam int ADDR_W   = 32;
	localparam int OFFSET_W = 6;   // 64-byte lines
	localparam int INDEX_W  = 10;
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
	localparam int TID_W    = 10;
	localparam int ID_W     = 4;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [TID_W-1:0]  tid_t;
	typedef logic [ID_W-1:0]   axid_t;
	typedef logic [7:0]        axlen_t;

	// one queued tag lookup, 43 bits
	typedef struct packed {
		logic  write;
		tid_t  tid;
		addr_t addr;
	} tag_entry_t;

	// stored tag word as returned by the memory controller
	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_word_t;

	typedef enum logic [1:0] {IDLE, RD_REQ, WR_REQ, PUSH} ix_state_e;

	function automatic tag_t tag_of(addr_t a);
		return a[ADDR_W-1 -: TAG_W];
	endfunction

	// keep only the index bits, tag and offset go to zero
	function automatic addr_t set_addr(addr_t a);
		addr_t s;
		s = '0;
		s[OFFSET_W +: INDEX_W] = a[OFFSET_W +: INDEX_W];
		return s;
	endfunction

endpackage

`default_nettype wire

//--- hw/tag_fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tag_push_if
	import dcache_pkg::*;
();
	logic  wren;   // one strobe per entry
	logic  write;
	tid_t  tid;
	addr_t addr;
	logic  afull;

	modport producer (output wren, write, tid, addr, input afull);
	modport fifo     (input wren, write, tid, addr, output afull);
endinterface

interface tag_pop_if
	import dcache_pkg::*;
();
	logic  rd_en;
	logic  write;  // head entry, valid while empty is low
	tid_t  tid;
	addr_t addr;
	logic  empty;

	modport consumer (output rd_en, input write, tid, addr, empty);
	modport fifo     (input rd_en, output write, tid, addr, empty);
endinterface

`default_nettype wire

//--- hw/index_extractor.sv
`timescale 1ns/1ps
`default_nettype none

module index_extractor
	import dcache_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,

	input  axid_t  ar_id_i,
	input  addr_t  ar_addr_i,
	input  axlen_t ar_len_i,
	input  logic   ar_valid_i,
	output logic   ar_ready_o,

	input  axid_t  aw_id_i,
	input  addr_t  aw_addr_i,
	input  axlen_t aw_len_i,
	input  logic   aw_valid_i,
	output logic   aw_ready_o,

	output axid_t  mem_arid_o,
	output addr_t  mem_araddr_o,
	output axlen_t mem_arlen_o,
	output logic   mem_arvalid_o,
	input  logic   mem_arready_i,

	tag_push_if.producer push
);

	ix_state_e  state;
	ix_state_e  state_n;
	logic       rdy_en;    // low through reset, readies stay off
	logic       wr_prio;   // write wins the next tie
	logic       can_take;
	logic       rd_take;
	logic       wr_take;
	tid_t       tid_cnt;
	tag_entry_t entry;
	axid_t      id_q;
	axlen_t     len_q;

	assign can_take = (state == IDLE) && rdy_en && !push.afull;

	// a ready only drops for the channel that loses a tie
	assign ar_ready_o = can_take && (!aw_valid_i || !wr_prio);
	assign aw_ready_o = can_take && (!ar_valid_i || wr_prio);

	assign rd_take = ar_valid_i && ar_ready_o;
	assign wr_take = aw_valid_i && aw_ready_o;

	always_comb begin
		state_n = state;
		case (state)
			IDLE: begin
				if (rd_take)
					state_n = RD_REQ;
				else if (wr_take)
					state_n = WR_REQ;
			end
			RD_REQ, WR_REQ: begin
				if (mem_arready_i)
					state_n = PUSH;   // tag read handed off
			end
			PUSH:    state_n = IDLE;
			default: state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= IDLE;
			rdy_en  <= 1'b0;
			wr_prio <= 1'b0;   // read goes first after reset
			tid_cnt <= tid_t'(1);
		end else begin
			state  <= state_n;
			rdy_en <= 1'b1;
			if (rd_take)
				wr_prio <= 1'b1;
			else if (wr_take)
				wr_prio <= 1'b0;
			if (rd_take || wr_take)
				tid_cnt <= tid_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_take) begin
			entry.write <= 1'b0;
			entry.tid   <= tid_cnt;
			entry.addr  <= ar_addr_i;
			id_q        <= ar_id_i;
			len_q       <= ar_len_i;
		end else if (wr_take) begin
			entry.write <= 1'b1;
			entry.tid   <= tid_cnt;
			entry.addr  <= aw_addr_i;   // write side looks up its own set
			id_q        <= aw_id_i;
			len_q       <= aw_len_i;
		end
	end

	assign mem_arvalid_o = (state == RD_REQ) || (state == WR_REQ);
	assign mem_araddr_o  = set_addr(entry.addr);
	assign mem_arid_o    = id_q;
	assign mem_arlen_o   = len_q;

	assign push.wren  = (state == PUSH);
	assign push.write = entry.write;
	assign push.tid   = entry.tid;
	assign push.addr  = entry.addr;

	// afull was low at acceptance, nothing else pushes before our strobe
	a_push_not_afull: assert property (@(posedge clk) disable iff (!rst_n)
		push.wren |-> !push.afull)
		else $error("tag push while FIFO almost full");

	a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o))
		else $error("mem_arvalid_o dropped before mem_arready_i");

endmodule

`default_nettype wire

//--- hw/tag_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tag_fifo
	import dcache_pkg::*;
#(
	parameter int FIFO_DEPTH  = 8,
	parameter int AFULL_LEVEL = FIFO_DEPTH - 1
) (
	input  logic clk,
	input  logic rst_n,
	tag_push_if.fifo push,
	tag_pop_if.fifo  pop
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	tag_entry_t       entries [FIFO_DEPTH];
	tag_entry_t       head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;

	// wraps at FIFO_DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	always_ff @(posedge clk) begin
		if (push.wren)
			entries[wr_ptr] <= '{write: push.write, tid: push.tid, addr: push.addr};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push.wren)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop.rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push.wren, pop.rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // none, or push and pop together
			endcase
		end
	end

	assign head      = entries[rd_ptr];   // fall-through head
	assign pop.write = head.write;
	assign pop.tid   = head.tid;
	assign pop.addr  = head.addr;

	assign pop.empty  = (count == '0);
	assign full       = (count == CNT_W'(FIFO_DEPTH));
	assign push.afull = (count >= CNT_W'(AFULL_LEVEL));

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push.wren |-> !full)
		else $error("tag FIFO overflow");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop.rd_en |-> !pop.empty)
		else $error("tag FIFO underflow");

endmodule

`default_nettype wire

//--- hw/tag_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tag_checker
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	input  logic      mem_rvalid_i,
	input  tag_word_t mem_rdata_i,

	tag_pop_if.consumer pop,

	output logic      result_valid_o,
	output logic      result_hit_o,
	output logic      result_write_o,
	output tid_t      result_tid_o,
	output addr_t     result_addr_o
);

	tag_t head_tag;
	logic tag_match;
	logic hit;

	// responses come back in request order, so the head is always the owner
	assign pop.rd_en = mem_rvalid_i && !pop.empty;

	assign head_tag  = tag_of(pop.addr);
	assign tag_match = (head_tag == mem_rdata_i.tag);
	assign hit       = mem_rdata_i.valid && tag_match;   // invalid line never hits

	always_ff @(posedge clk) begin
		if (!rst_n)
			result_valid_o <= 1'b0;
		else
			result_valid_o <= pop.rd_en;   // single cycle strobe
	end

	always_ff @(posedge clk) begin
		if (pop.rd_en) begin
			result_hit_o   <= hit;
			result_write_o <= pop.write;
			result_tid_o   <= pop.tid;
			result_addr_o  <= pop.addr;
		end
	end

	// a response without a queued lookup means the request path lost an entry
	a_resp_has_entry: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rvalid_i |-> !pop.empty)
		else $error("tag response with empty tag FIFO");

endmodule

`default_nettype wire

//--- hw/dcache_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_frontend
	import dcache_pkg::*;
#(
	parameter int FIFO_DEPTH  = 8,
	parameter int AFULL_LEVEL = FIFO_DEPTH - 1
) (
	input  logic      clk,
	input  logic      rst_n,

	input  axid_t     ar_id_i,
	input  addr_t     ar_addr_i,
	input  axlen_t    ar_len_i,
	input  logic      ar_valid_i,
	output logic      ar_ready_o,

	input  axid_t     aw_id_i,
	input  addr_t     aw_addr_i,
	input  axlen_t    aw_len_i,
	input  logic      aw_valid_i,
	output logic      aw_ready_o,

	output axid_t     mem_arid_o,
	output addr_t     mem_araddr_o,
	output axlen_t    mem_arlen_o,
	output logic      mem_arvalid_o,
	input  logic      mem_arready_i,

	input  logic      mem_rvalid_i,
	input  tag_word_t mem_rdata_i,

	output logic      result_valid_o,
	output logic      result_hit_o,
	output logic      result_write_o,
	output tid_t      result_tid_o,
	output addr_t     result_addr_o
);

	tag_push_if u_push ();
	tag_pop_if  u_pop ();

	index_extractor i_index_extractor (
		.clk           (clk),
		.rst_n         (rst_n),
		.ar_id_i       (ar_id_i),
		.ar_addr_i     (ar_addr_i),
		.ar_len_i      (ar_len_i),
		.ar_valid_i    (ar_valid_i),
		.ar_ready_o    (ar_ready_o),
		.aw_id_i       (aw_id_i),
		.aw_addr_i     (aw_addr_i),
		.aw_len_i      (aw_len_i),
		.aw_valid_i    (aw_valid_i),
		.aw_ready_o    (aw_ready_o),
		.mem_arid_o    (mem_arid_o),
		.mem_araddr_o  (mem_araddr_o),
		.mem_arlen_o   (mem_arlen_o),
		.mem_arvalid_o (mem_arvalid_o),
		.mem_arready_i (mem_arready_i),
		.push          (u_push.producer)
	);

	tag_fifo #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.AFULL_LEVEL (AFULL_LEVEL)
	) i_tag_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.push  (u_push.fifo),
		.pop   (u_pop.fifo)
	);

	tag_checker i_tag_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_rvalid_i   (mem_rvalid_i),
		.mem_rdata_i    (mem_rdata_i),
		.pop            (u_pop.consumer),
		.result_valid_o (result_valid_o),
		.result_hit_o   (result_hit_o),
		.result_write_o (result_write_o),
		.result_tid_o   (result_tid_o),
		.result_addr_o  (result_addr_o)
	);

endmodule

`default_nettype wire

//--- test/tb_dcache_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_frontend
	import dcache_pkg::*;
();

	localparam int FIFO_DEPTH  = 8;
	localparam int AFULL_LEVEL = FIFO_DEPTH - 1;
	localparam int TIMEOUT     = 2000;
	localparam addr_t SET_MASK = 32'h0000_ffc0;   // index bits 15:6

	typedef struct packed {
		logic  write;
		tid_t  tid;
		addr_t addr;
		logic  hit;
	} exp_res_t;

	typedef struct packed {
		addr_t  addr;
		axid_t  id;
		axlen_t len;
	} exp_req_t;

	typedef struct packed {
		int                 due;
		logic [INDEX_W-1:0] idx;
	} pend_resp_t;

	logic      clk;
	logic      rst_n;
	axid_t     ar_id_i;
	addr_t     ar_addr_i;
	axlen_t    ar_len_i;
	logic      ar_valid_i;
	logic      ar_ready_o;
	axid_t     aw_id_i;
	addr_t     aw_addr_i;
	axlen_t    aw_len_i;
	logic      aw_valid_i;
	logic      aw_ready_o;
	axid_t     mem_arid_o;
	addr_t     mem_araddr_o;
	axlen_t    mem_arlen_o;
	logic      mem_arvalid_o;
	logic      mem_arready_i;
	logic      mem_rvalid_i;
	tag_word_t mem_rdata_i;
	logic      result_valid_o;
	logic      result_hit_o;
	logic      result_write_o;
	tid_t      result_tid_o;
	addr_t     result_addr_o;

	tag_word_t   tag_table [1024];   // memory model, one tag word per set
	exp_res_t    sb_q[$];
	exp_req_t    req_q[$];
	pend_resp_t  resp_q[$];
	exp_res_t    res_exp;
	exp_req_t    req_exp;
	pend_resp_t  resp_head;
	int          errors;
	int          checks;
	int          cyc;
	int          ar_delay;
	tid_t        next_tid;
	logic        last_write;
	logic        hold_arready;
	logic        hold_resp;
	logic [16:0] mem_lfsr;
	logic [16:0] stim_lfsr;
	logic [31:0] mem_rand;

	dcache_frontend #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.AFULL_LEVEL (AFULL_LEVEL)
	) i_dcache_frontend (.*);

	always #20 clk = ~clk;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic draw_bits(inout logic [16:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			v  = {v[30:0], st[0]};
		end
	endtask

	function automatic logic expect_hit(addr_t a);
		tag_word_t w;
		w = tag_table[a[15:6]];
		return w.valid && (w.tag == a[31:16]);
	endfunction

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s expected %h got %h at %0t", name, exp, got, $time);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	task automatic timed_out(input string what);
		errors++;
		$display("timed out waiting for %s", what);
		finish_run();
	endtask

	// expected result and memory request are booked in acceptance order
	task automatic book(input logic wr, input addr_t a, input axid_t id, input axlen_t len);
		exp_res_t r;
		exp_req_t q;
		r.write = wr;
		r.tid   = next_tid;
		r.addr  = a;
		r.hit   = expect_hit(a);
		q.addr  = a & SET_MASK;
		q.id    = id;
		q.len   = len;
		sb_q.push_back(r);
		req_q.push_back(q);
		next_tid++;
		last_write = wr;
	endtask

	task automatic await_accept(input string what);
		int   t;
		logic rd_take;
		logic wr_take;
		t = 0;
		while (ar_valid_i || aw_valid_i) begin
			#5;
			rd_take = ar_valid_i && ar_ready_o;
			wr_take = aw_valid_i && aw_ready_o;
			@(negedge clk);
			if (rd_take)
				ar_valid_i = 1'b0;
			if (wr_take)
				aw_valid_i = 1'b0;
			t++;
			if (t > TIMEOUT)
				timed_out(what);
		end
	endtask

	task automatic issue_req(input logic wr, input addr_t a, input axid_t id, input axlen_t len);
		book(wr, a, id, len);
		if (wr) begin
			aw_addr_i  = a;
			aw_id_i    = id;
			aw_len_i   = len;
			aw_valid_i = 1'b1;
		end else begin
			ar_addr_i  = a;
			ar_id_i    = id;
			ar_len_i   = len;
			ar_valid_i = 1'b1;
		end
		await_accept(wr ? "aw_ready_o" : "ar_ready_o");
	endtask

	// both channels valid, the one that did not go last wins the tie
	task automatic issue_pair(input addr_t ra, input addr_t wa, input axid_t id, input axlen_t len);
		if (last_write) begin
			book(1'b0, ra, id, len);
			book(1'b1, wa, id + 1'b1, len + 1'b1);
		end else begin
			book(1'b1, wa, id + 1'b1, len + 1'b1);
			book(1'b0, ra, id, len);
		end
		ar_addr_i  = ra;
		ar_id_i    = id;
		ar_len_i   = len;
		aw_addr_i  = wa;
		aw_id_i    = id + 1'b1;
		aw_len_i   = len + 1'b1;
		ar_valid_i = 1'b1;
		aw_valid_i = 1'b1;
		await_accept("read and write acceptance");
	endtask

	task automatic set_tag(input int idx, input logic v, input tag_t t);
		@(posedge clk);
		tag_table[idx] = {v, t};
		@(negedge clk);
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		#5;
		while (sb_q.size() != 0 || resp_q.size() != 0) begin
			@(negedge clk);
			#5;
			t++;
			if (t > TIMEOUT)
				timed_out("outstanding results");
		end
		@(negedge clk);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (15) @(negedge clk);
		check_eq("ar_ready_o", 0, ar_ready_o);
		check_eq("aw_ready_o", 0, aw_ready_o);
		@(negedge clk);
		rst_n      = 1'b1;
		next_tid   = tid_t'(1);
		last_write = 1'b1;   // read wins the first tie
		@(negedge clk);
		check_eq("ar_ready_o", 1, ar_ready_o);
		check_eq("aw_ready_o", 1, aw_ready_o);
		check_eq("mem_arvalid_o", 0, mem_arvalid_o);
		check_eq("result_valid_o", 0, result_valid_o);
	endtask

	task automatic alternation_order();
		set_tag(1, 1'b1, 16'h1000);
		for (int k = 0; k < 3; k++)
			issue_pair(32'h1000_0040 + k * 32'h0101_0080, 32'h2000_0100 + k * 32'h0011_0040,
				axid_t'(2 * k), axlen_t'(k + 1));
		issue_req(1'b0, 32'h1000_0040, 4'h5, 8'h02);   // a lone read hands the next tie to the write
		issue_pair(32'h1000_0080, 32'h2000_0100, 4'h6, 8'h03);
		wait_drain();
	endtask

	task automatic hit_miss_lookup();
		set_tag(10'h2a5, 1'b1, 16'hbeef);
		issue_req(1'b0, {16'hbeef, 10'h2a5, 6'h15}, 4'h9, 8'h07);
		wait_drain();
		issue_req(1'b1, {16'hbeee, 10'h2a5, 6'h00}, 4'h3, 8'h00);   // tag mismatch
		issue_req(1'b1, {16'hbeef, 10'h2a5, 6'h3f}, 4'h4, 8'hff);
		wait_drain();
		set_tag(10'h2a5, 1'b0, 16'hbeef);
		issue_req(1'b0, {16'hbeef, 10'h2a5, 6'h08}, 4'hc, 8'h01);
		wait_drain();
	endtask

	task automatic backpressure_hold();
		int t;
		@(posedge clk);
		hold_arready = 1'b1;
		@(negedge clk);
		issue_req(1'b0, 32'hcafe_1234, 4'h1, 8'h03);
		repeat (8) begin
			@(negedge clk);
			check_eq("mem_arvalid_o", 1, mem_arvalid_o);
			check_eq("mem_araddr_o", 32'hcafe_1234 & SET_MASK, mem_araddr_o);
			check_eq("ar_ready_o", 0, ar_ready_o);
			check_eq("aw_ready_o", 0, aw_ready_o);
		end
		@(posedge clk);
		hold_arready = 1'b0;
		hold_resp    = 1'b1;
		@(negedge clk);
		for (int k = 1; k < AFULL_LEVEL; k++)
			issue_req(k[0], 32'h0bad_0000 + k * 32'h0000_0440, axid_t'(k), axlen_t'(k));
		t = 0;
		#5;
		while (req_q.size() != 0) begin
			@(negedge clk);
			#5;
			t++;
			if (t > TIMEOUT)
				timed_out("tag requests to memory");
		end
		repeat (6) begin
			@(negedge clk);
			check_eq("ar_ready_o", 0, ar_ready_o);
			check_eq("aw_ready_o", 0, aw_ready_o);
		end
		@(posedge clk);
		hold_resp = 1'b0;
		@(negedge clk);
		wait_drain();
	endtask

	task automatic random_traffic();
		logic [31:0]        v;
		logic [INDEX_W-1:0] idx;
		tag_t               t;
		logic [1:0]         gap;
		@(posedge clk);
		for (int s = 0; s < 16; s++) begin
			draw_bits(stim_lfsr, 17, v);
			tag_table[s * 61 + 7] = {v[16] | v[15], v[15:0]};   // mostly valid
		end
		@(negedge clk);
		for (int k = 0; k < 40; k++) begin
			draw_bits(stim_lfsr, 4, v);
			idx = INDEX_W'(v[3:0] * 61 + 7);
			draw_bits(stim_lfsr, 17, v);
			t = v[16] ? tag_table[idx].tag : v[15:0];
			draw_bits(stim_lfsr, 21, v);
			gap = v[20:19];
			issue_req(v[6], {t, idx, v[5:0]}, v[18:15], v[14:7]);
			repeat (gap) @(negedge clk);
		end
		wait_drain();
	endtask

	// memory controller model
	always @(negedge clk) begin : mem_model
		mem_arready_i = 1'b0;
		mem_rvalid_i  = 1'b0;
		if (!rst_n) begin
			cyc      = 0;
			ar_delay = 0;
		end else begin
			cyc++;
			if (mem_arvalid_o && !hold_arready) begin
				if (ar_delay != 0) begin
					ar_delay--;
				end else begin
					mem_arready_i = 1'b1;   // handshake at the next rising edge
					if (req_q.size() == 0) begin
						errors++;
						$display("memory tag request that no processor request asked for");
					end else begin
						req_exp = req_q.pop_front();
						check_eq("mem_araddr_o", req_exp.addr, mem_araddr_o);
						check_eq("mem_arid_o", req_exp.id, mem_arid_o);
						check_eq("mem_arlen_o", req_exp.len, mem_arlen_o);
					end
					draw_bits(mem_lfsr, 2, mem_rand);
					resp_head.due = cyc + 2 + int'(mem_rand[1:0]);   // entry is in the FIFO by then
					resp_head.idx = mem_araddr_o[15:6];
					resp_q.push_back(resp_head);
					draw_bits(mem_lfsr, 2, mem_rand);
					ar_delay = int'(mem_rand[1:0]);
				end
			end
			if (!hold_resp && resp_q.size() != 0 && cyc >= resp_q[0].due) begin
				resp_head    = resp_q.pop_front();
				mem_rvalid_i = 1'b1;
				mem_rdata_i  = tag_table[resp_head.idx];
			end
		end
	end

	always @(negedge clk) begin : result_check
		if (rst_n && result_valid_o) begin
			if (sb_q.size() == 0) begin
				errors++;
				$display("result strobe with no outstanding request, tid %h", result_tid_o);
			end else begin
				res_exp = sb_q.pop_front();
				check_eq("result_tid_o", res_exp.tid, result_tid_o);
				check_eq("result_write_o", res_exp.write, result_write_o);
				check_eq("result_addr_o", res_exp.addr, result_addr_o);
				check_eq("result_hit_o", res_exp.hit, result_hit_o);
			end
		end
	end

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		ar_id_i      = '0;
		ar_addr_i    = '0;
		ar_len_i     = '0;
		ar_valid_i   = 1'b0;
		aw_id_i      = '0;
		aw_addr_i    = '0;
		aw_len_i     = '0;
		aw_valid_i   = 1'b0;
		mem_arready_i = 1'b0;
		mem_rvalid_i = 1'b0;
		mem_rdata_i  = '0;
		hold_arready = 1'b0;
		hold_resp    = 1'b0;
		errors       = 0;
		checks       = 0;
		next_tid     = tid_t'(1);
		last_write   = 1'b1;
		mem_lfsr     = 17'd81823;
		stim_lfsr    = 17'd81823;
		for (int i = 0; i < 1024; i++)
			tag_table[i] = '0;
		apply_reset();
		alternation_order();
		hit_miss_lookup();
		backpressure_hold();
		random_traffic();
		finish_run();
	end

endmodule

`default_nettype wire

//--- src.f
hw/dcache_pkg.sv
hw/tag_fifo_if.sv
hw/index_extractor.sv
hw/tag_fifo.sv
hw/tag_checker.sv
hw/dcache_frontend.sv
test/tb_dcache_frontend.sv
